//--- source/serial_link_config.svh
////////////////////////////////////////
// Serial link configuration
////////////////////////////////////////

`ifndef SERIAL_LINK_CONFIG_SVH
`define SERIAL_LINK_CONFIG_SVH

// Payload and wire geometry
`define SL_PAYLOAD_W 32
`define SL_NUM_LANES 4
`define SL_BEATS (`SL_PAYLOAD_W / `SL_NUM_LANES)

// Entries in each payload FIFO
`define SL_FIFO_DEPTH 4

// Forwarded clock divider range
`define SL_MIN_CLK_DIV 4
`define SL_MAX_CLK_DIV 64
`define SL_CLK_DIV_W 7

// AXI4-Lite bus geometry
`define SL_AXIL_ADDR_W 5
`define SL_AXIL_DATA_W 32

// Register byte offsets
`define SL_REG_CTRL 5'h00
`define SL_REG_CLK_DIV 5'h04
`define SL_REG_STATUS 5'h08
`define SL_REG_TX_COUNT 5'h0C
`define SL_REG_RX_COUNT 5'h10

`endif

//--- source/serial_link_pkg.sv
////////////////////////////////////////
// Serial link types
////////////////////////////////////////

`include "serial_link_config.svh"

package serial_link_pkg;

  typedef logic [`SL_PAYLOAD_W-1:0] payload_t;
  typedef logic [`SL_NUM_LANES-1:0] lanes_t;
  typedef logic [`SL_CLK_DIV_W-1:0] clk_div_t;
  typedef logic [$clog2(`SL_FIFO_DEPTH + 1)-1:0] fill_t;

  // Control fields from the register block
  typedef struct packed {
    logic     link_en;
    logic     isolate_in;
    logic     isolate_out;
    clk_div_t clk_div;
  } link_ctrl_t;

  // Status and event pulses toward the register block
  typedef struct packed {
    logic [1:0] isolated;
    fill_t      rx_fill;
    logic       tx_done;
    logic       rx_done;
  } link_stat_t;

  ////////////////////////////////////////
  // AXI4-Lite
  ////////////////////////////////////////

  typedef struct packed {
    logic [`SL_AXIL_ADDR_W-1:0]   awaddr;
    logic                         awvalid;
    logic [`SL_AXIL_DATA_W-1:0]   wdata;
    logic [`SL_AXIL_DATA_W/8-1:0] wstrb;
    logic                         wvalid;
    logic                         bready;
    logic [`SL_AXIL_ADDR_W-1:0]   araddr;
    logic                         arvalid;
    logic                         rready;
  } axil_req_t;

  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       arready;
    logic [`SL_AXIL_DATA_W-1:0] rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
  } axil_rsp_t;

endpackage

//--- source/sl_fifo.sv
////////////////////////////////////////
// Payload FIFO
////////////////////////////////////////

`include "serial_link_config.svh"

module sl_fifo #(
  parameter int unsigned Depth = `SL_FIFO_DEPTH
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      push_i,
  input  serial_link_pkg::payload_t data_i,
  output logic                      full_o,
  input  logic                      pop_i,
  output serial_link_pkg::payload_t data_o,
  output logic                      empty_o,
  output serial_link_pkg::fill_t    fill_o
);

  import serial_link_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  logic [CntW-1:0] count_q;
  logic            push_ok;
  logic            pop_ok;

  // Wrap at Depth so non-trivial depths also index correctly
  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;
  assign data_o  = mem_q[rptr_q];
  assign fill_o  = fill_t'(count_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_ok) wptr_q <= next_ptr(wptr_q);
      if (pop_ok) rptr_q <= next_ptr(rptr_q);
      // Simultaneous push and pop leaves the count unchanged
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wptr_q] <= data_i;
  end

endmodule

//--- source/sl_cfg_regs.sv
////////////////////////////////////////
// Serial link registers
////////////////////////////////////////

`include "serial_link_config.svh"

module sl_cfg_regs (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  serial_link_pkg::axil_req_t  axil_req_i,
  output serial_link_pkg::axil_rsp_t  axil_rsp_o,
  output serial_link_pkg::link_ctrl_t ctrl_o,
  input  serial_link_pkg::link_stat_t stat_i
);

  import serial_link_pkg::*;

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlverr = 2'b10;

  link_ctrl_t  ctrl_q;
  logic [31:0] tx_count_q;
  logic [31:0] rx_count_q;

  logic        wr_fire;
  logic        wr_ok;
  logic        rd_fire;
  logic        bvalid_q;
  logic [1:0]  bresp_q;
  logic        rvalid_q;
  logic [1:0]  rresp_q;
  logic [31:0] rdata_q;
  logic [1:0]  rresp_d;
  logic [31:0] rdata_d;

  // Force even, then clamp to the supported divider range
  function automatic clk_div_t clamp_div(logic [31:0] value);
    logic [31:0] even;
    even = {value[31:1], 1'b0};
    if (even < 32'(`SL_MIN_CLK_DIV)) begin
      return clk_div_t'(`SL_MIN_CLK_DIV);
    end
    if (even > 32'(`SL_MAX_CLK_DIV)) begin
      return clk_div_t'(`SL_MAX_CLK_DIV);
    end
    return clk_div_t'(even);
  endfunction

  ////////////////////////////////////////
  // Write path
  ////////////////////////////////////////

  assign wr_fire = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
  assign wr_ok   = (axil_req_i.awaddr == `SL_REG_CTRL) ||
                   (axil_req_i.awaddr == `SL_REG_CLK_DIV);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q.link_en     <= 1'b0;
      ctrl_q.isolate_in  <= 1'b0;
      ctrl_q.isolate_out <= 1'b0;
      ctrl_q.clk_div     <= clk_div_t'(`SL_MIN_CLK_DIV);
      bvalid_q           <= 1'b0;
      bresp_q            <= RespOkay;
    end else begin
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_ok ? RespOkay : RespSlverr;
        if (axil_req_i.awaddr == `SL_REG_CTRL) begin
          ctrl_q.link_en     <= axil_req_i.wdata[0];
          ctrl_q.isolate_in  <= axil_req_i.wdata[1];
          ctrl_q.isolate_out <= axil_req_i.wdata[2];
        end
        if (axil_req_i.awaddr == `SL_REG_CLK_DIV) begin
          ctrl_q.clk_div <= clamp_div(axil_req_i.wdata);
        end
      end else if (bvalid_q && axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // Payload counters wrap at 32 bits
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_count_q <= '0;
      rx_count_q <= '0;
    end else begin
      tx_count_q <= tx_count_q + 32'(stat_i.tx_done);
      rx_count_q <= rx_count_q + 32'(stat_i.rx_done);
    end
  end

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////

  assign rd_fire = axil_req_i.arvalid & ~rvalid_q;

  always_comb begin
    rdata_d = '0;
    rresp_d = RespOkay;
    case (axil_req_i.araddr)
      `SL_REG_CTRL: begin
        rdata_d[0] = ctrl_q.link_en;
        rdata_d[1] = ctrl_q.isolate_in;
        rdata_d[2] = ctrl_q.isolate_out;
      end
      `SL_REG_CLK_DIV:  rdata_d[`SL_CLK_DIV_W-1:0] = ctrl_q.clk_div;
      `SL_REG_STATUS: begin
        rdata_d[1:0] = stat_i.isolated;
        rdata_d[6:4] = stat_i.rx_fill;
      end
      `SL_REG_TX_COUNT: rdata_d = tx_count_q;
      `SL_REG_RX_COUNT: rdata_d = rx_count_q;
      default:          rresp_d = RespSlverr;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rresp_q  <= RespOkay;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
      rresp_q  <= rresp_d;
    end else if (rvalid_q && axil_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) rdata_q <= rdata_d;
  end

  // Address and data are accepted together in one cycle
  always_comb begin
    axil_rsp_o.awready = wr_fire;
    axil_rsp_o.wready  = wr_fire;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.arready = rd_fire;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
    axil_rsp_o.rvalid  = rvalid_q;
  end

  assign ctrl_o = ctrl_q;

endmodule

//--- source/sl_tx_phy.sv
////////////////////////////////////////
// Serial link transmit PHY
////////////////////////////////////////

`include "serial_link_config.svh"

module sl_tx_phy (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  serial_link_pkg::link_ctrl_t ctrl_i,
  input  logic                        in_valid_i,
  input  serial_link_pkg::payload_t   in_data_i,
  output logic                        in_ready_o,
  output logic                        ddr_rcv_clk_o,
  output serial_link_pkg::lanes_t     ddr_o,
  output logic                        tx_done_o
);

  import serial_link_pkg::*;

  localparam int unsigned BeatW = $clog2(`SL_BEATS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_GAP
  } tx_state_e;

  tx_state_e        state_q;
  logic             fifo_full;
  logic             fifo_empty;
  logic             push;
  logic             pop;
  logic             tick;
  payload_t         fifo_data;
  payload_t         shift_q;
  clk_div_t         half_q;
  clk_div_t         div_cnt_q;
  logic [BeatW-1:0] beat_q;

  assign in_ready_o = ctrl_i.link_en & ~ctrl_i.isolate_in & ~fifo_full;
  assign push       = in_valid_i & in_ready_o;
  assign tx_done_o  = push;
  // New payloads only start while the link is enabled
  assign pop        = (state_q == ST_IDLE) & ctrl_i.link_en & ~fifo_empty;
  assign tick       = (div_cnt_q == '0);

  sl_fifo #(
    .Depth ( `SL_FIFO_DEPTH )
  ) i_tx_fifo (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .push_i  ( push       ),
    .data_i  ( in_data_i  ),
    .full_o  ( fifo_full  ),
    .pop_i   ( pop        ),
    .data_o  ( fifo_data  ),
    .empty_o ( fifo_empty ),
    .fill_o  (            )
  );

  ////////////////////////////////////////
  // Serializer
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= ST_IDLE;
      ddr_rcv_clk_o <= 1'b0;
      ddr_o         <= '0;
      half_q        <= clk_div_t'(`SL_MIN_CLK_DIV / 2);
      div_cnt_q     <= '0;
      beat_q        <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (pop) begin
            // Divider is latched so a register write never splits a payload
            state_q   <= ST_SEND;
            half_q    <= ctrl_i.clk_div >> 1;
            div_cnt_q <= (ctrl_i.clk_div >> 1) - 1'b1;
            beat_q    <= '0;
          end
        end
        ST_SEND: begin
          if (tick) begin
            ddr_rcv_clk_o <= ~ddr_rcv_clk_o;
            ddr_o         <= shift_q[`SL_NUM_LANES-1:0];
            div_cnt_q     <= half_q - 1'b1;
            beat_q        <= beat_q + 1'b1;
            if (beat_q == BeatW'(`SL_BEATS - 1)) state_q <= ST_GAP;
          end else begin
            div_cnt_q <= div_cnt_q - 1'b1;
          end
        end
        ST_GAP: begin
          // Clock stays low for half a period before the next payload
          if (tick) begin
            state_q <= ST_IDLE;
          end else begin
            div_cnt_q <= div_cnt_q - 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Least significant nibble goes out first
  always_ff @(posedge clk_i) begin
    if (pop) begin
      shift_q <= fifo_data;
    end else if (state_q == ST_SEND && tick) begin
      shift_q <= shift_q >> `SL_NUM_LANES;
    end
  end

endmodule

//--- source/sl_rx_phy.sv
////////////////////////////////////////
// Serial link receive PHY
////////////////////////////////////////

`include "serial_link_config.svh"

module sl_rx_phy (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  serial_link_pkg::link_ctrl_t ctrl_i,
  input  logic                        ddr_rcv_clk_i,
  input  serial_link_pkg::lanes_t     ddr_i,
  output logic                        out_valid_o,
  output serial_link_pkg::payload_t   out_data_o,
  input  logic                        out_ready_i,
  output serial_link_pkg::fill_t      rx_fill_o,
  output logic                        rx_done_o
);

  import serial_link_pkg::*;

  localparam int unsigned BeatW = $clog2(`SL_BEATS);

  logic             clk_s1_q;
  logic             clk_s2_q;
  logic             clk_prev_q;
  lanes_t           ddr_s1_q;
  lanes_t           ddr_s2_q;
  logic             edge_det;
  logic [BeatW-1:0] edge_cnt_q;
  payload_t         shift_q;
  payload_t         word;
  logic             push;
  logic             pop;
  logic             fifo_full;
  logic             fifo_empty;

  // Clock and lanes share the same two-stage delay to keep them aligned
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      clk_s1_q   <= 1'b0;
      clk_s2_q   <= 1'b0;
      clk_prev_q <= 1'b0;
    end else begin
      clk_s1_q   <= ddr_rcv_clk_i;
      clk_s2_q   <= clk_s1_q;
      clk_prev_q <= clk_s2_q;
    end
  end

  always_ff @(posedge clk_i) begin
    ddr_s1_q <= ddr_i;
    ddr_s2_q <= ddr_s1_q;
  end

  ////////////////////////////////////////
  // Deserializer
  ////////////////////////////////////////

  // Either edge of the forwarded clock carries a beat
  assign edge_det = clk_s2_q ^ clk_prev_q;
  assign word     = {ddr_s2_q, shift_q[`SL_PAYLOAD_W-1:`SL_NUM_LANES]};
  assign push     = edge_det & ctrl_i.link_en & (edge_cnt_q == BeatW'(`SL_BEATS - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      edge_cnt_q <= '0;
    end else if (!ctrl_i.link_en) begin
      edge_cnt_q <= '0;
    end else if (edge_det) begin
      edge_cnt_q <= edge_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (edge_det) shift_q <= word;
  end

  sl_fifo #(
    .Depth ( `SL_FIFO_DEPTH )
  ) i_rx_fifo (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .push_i  ( push       ),
    .data_i  ( word       ),
    .full_o  ( fifo_full  ),
    .pop_i   ( pop        ),
    .data_o  ( out_data_o ),
    .empty_o ( fifo_empty ),
    .fill_o  ( rx_fill_o  )
  );

  // A payload arriving at a full FIFO is dropped and not counted
  assign rx_done_o   = push & ~fifo_full;
  assign out_valid_o = ~ctrl_i.isolate_out & ~fifo_empty;
  assign pop         = out_valid_o & out_ready_i;

endmodule

//--- source/serial_link.sv
////////////////////////////////////////
// Serial link top level
////////////////////////////////////////

module serial_link (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Register access
  input  serial_link_pkg::axil_req_t axil_req_i,
  output serial_link_pkg::axil_rsp_t axil_rsp_o,
  // Payload input stream
  input  logic                       in_valid_i,
  input  serial_link_pkg::payload_t  in_data_i,
  output logic                       in_ready_o,
  // Payload output stream
  output logic                       out_valid_o,
  output serial_link_pkg::payload_t  out_data_o,
  input  logic                       out_ready_i,
  // Off-chip wire
  input  logic                       ddr_rcv_clk_i,
  output logic                       ddr_rcv_clk_o,
  input  serial_link_pkg::lanes_t    ddr_i,
  output serial_link_pkg::lanes_t    ddr_o,
  // Isolation handshake and clock gate
  input  logic [1:0]                 isolated_i,
  output logic [1:0]                 isolate_o,
  output logic                       clk_ena_o
);

  import serial_link_pkg::*;

  link_ctrl_t ctrl;
  link_stat_t stat;
  logic       tx_done;
  logic       rx_done;
  fill_t      rx_fill;

  ////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////

  sl_cfg_regs i_cfg_regs (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .axil_req_i ( axil_req_i ),
    .axil_rsp_o ( axil_rsp_o ),
    .ctrl_o     ( ctrl       ),
    .stat_i     ( stat       )
  );

  always_comb begin
    stat.isolated = isolated_i;
    stat.rx_fill  = rx_fill;
    stat.tx_done  = tx_done;
    stat.rx_done  = rx_done;
  end

  // Bit 0 isolates the input side, bit 1 the output side
  assign isolate_o = {ctrl.isolate_out, ctrl.isolate_in};
  assign clk_ena_o = ctrl.link_en;

  ////////////////////////////////////////
  // Physical layer
  ////////////////////////////////////////

  sl_tx_phy i_tx_phy (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .ctrl_i        ( ctrl          ),
    .in_valid_i    ( in_valid_i    ),
    .in_data_i     ( in_data_i     ),
    .in_ready_o    ( in_ready_o    ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o ),
    .ddr_o         ( ddr_o         ),
    .tx_done_o     ( tx_done       )
  );

  sl_rx_phy i_rx_phy (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .ctrl_i        ( ctrl          ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_i ),
    .ddr_i         ( ddr_i         ),
    .out_valid_o   ( out_valid_o   ),
    .out_data_o    ( out_data_o    ),
    .out_ready_i   ( out_ready_i   ),
    .rx_fill_o     ( rx_fill       ),
    .rx_done_o     ( rx_done       )
  );

endmodule

//--- tb/tb_serial_link.sv
////////////////////////////////////////
// Serial link testbench
////////////////////////////////////////

`include "serial_link_config.svh"

module tb_serial_link;

  timeunit 1ns;
  timeprecision 100ps;

  import serial_link_pkg::*;

  localparam int unsigned ClkPeriod    = 20;
  localparam int unsigned ResetCycles  = 16;
  localparam int unsigned NumBatches   = 10;
  localparam int unsigned BatchLen     = 20;
  localparam int unsigned NumPayloads  = NumBatches * BatchLen;
  localparam int unsigned IsoPayloads  = 3;
  localparam int unsigned IsoInCycles  = 40;
  localparam int unsigned MaxDiv       = 16;
  localparam int unsigned RegAccesses  = 200;
  localparam int unsigned AccessCycles = 8;
  localparam int unsigned TimeoutCycles = ResetCycles + RegAccesses * AccessCycles +
      IsoInCycles + (NumPayloads + IsoPayloads) * (4 * MaxDiv + 16) * 2;

  localparam logic [1:0]  RespOkay   = 2'b00;
  localparam logic [1:0]  RespSlverr = 2'b10;
  localparam logic [15:0] LfsrSeed   = 16'd31389;

  logic        clk = 1'b0;
  logic        rst_n;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic        in_valid;
  payload_t    in_data;
  logic        in_ready;
  logic        out_valid;
  payload_t    out_data;
  logic        out_ready;
  // Loopback nets driven and read back by the DUT
  logic        ddr_clk;
  lanes_t      ddr_lanes;
  logic [1:0]  iso;
  logic        clk_ena;

  payload_t    model_q[$];
  logic [15:0] lfsr_q;
  int unsigned check_cnt  = 0;
  int unsigned error_cnt  = 0;
  int unsigned cycle_cnt  = 0;
  int unsigned sent_total = 0;

  always #(ClkPeriod / 2) clk = ~clk;

  serial_link dut_i (
    .clk_i         ( clk       ),
    .rst_n_i       ( rst_n     ),
    .axil_req_i    ( axil_req  ),
    .axil_rsp_o    ( axil_rsp  ),
    .in_valid_i    ( in_valid  ),
    .in_data_i     ( in_data   ),
    .in_ready_o    ( in_ready  ),
    .out_valid_o   ( out_valid ),
    .out_data_o    ( out_data  ),
    .out_ready_i   ( out_ready ),
    .ddr_rcv_clk_i ( ddr_clk   ),
    .ddr_rcv_clk_o ( ddr_clk   ),
    .ddr_i         ( ddr_lanes ),
    .ddr_o         ( ddr_lanes ),
    .isolated_i    ( iso       ),
    .isolate_o     ( iso       ),
    .clk_ena_o     ( clk_ena   )
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      value  = {value[30:0], fb};
    end
    return value;
  endfunction

  // Expected divider after dropping bit 0 and holding inside the legal range
  function automatic logic [31:0] expected_div(input logic [31:0] raw);
    logic [31:0] even;
    even = raw - (raw % 2);
    if (even < `SL_MIN_CLK_DIV) begin
      return `SL_MIN_CLK_DIV;
    end
    if (even > `SL_MAX_CLK_DIV) begin
      return `SL_MAX_CLK_DIV;
    end
    return even;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    @(posedge clk);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hF;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.awready) @(negedge clk);
    check_value("wready", 32'(axil_rsp.wready), 1);
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.bvalid) @(negedge clk);
    resp = axil_rsp.bresp;
    @(posedge clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge clk);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready) @(negedge clk);
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.rvalid) @(negedge clk);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk);
    axil_req.rready <= 1'b0;
  endtask

  task automatic expect_write(input logic [4:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp, input string name);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    check_value({name, " bresp"}, 32'(resp), 32'(exp_resp));
  endtask

  task automatic expect_read(input logic [4:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp, input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    check_value({name, " rdata"}, data, exp_data);
    check_value({name, " rresp"}, 32'(resp), 32'(exp_resp));
  endtask

  // Sends n_send random payloads and takes n_recv from the output
  task automatic run_stream(input int unsigned n_send, input int unsigned n_recv,
                            input logic stall);
    int unsigned offered;
    int unsigned accepted;
    int unsigned received;
    int unsigned run_left;
    logic        took;
    logic        ready_state;
    offered     = 0;
    accepted    = 0;
    received    = 0;
    run_left    = 0;
    ready_state = 1'b1;
    while (accepted < n_send || received < n_recv) begin
      // Handshakes are settled half a cycle before the edge that completes them
      @(negedge clk);
      took = in_valid & in_ready;
      if (took) begin
        model_q.push_back(in_data);
        accepted++;
        sent_total++;
      end
      if (out_valid && out_ready) begin
        if (model_q.size() == 0) begin
          error_cnt++;
          $display("Payload 0x%08h came out at %0t ns with none outstanding", out_data, $time);
        end else begin
          check_value("out_data_o", out_data, model_q.pop_front());
        end
        received++;
      end
      @(posedge clk);
      if (!in_valid || took) begin
        if (offered < n_send) begin
          in_valid <= 1'b1;
          in_data  <= rand_bits(32);
          offered++;
        end else begin
          in_valid <= 1'b0;
        end
      end
      if (stall) begin
        if (run_left == 0) begin
          ready_state = ~ready_state;
          // Low runs last at most 32 cycles and stay inside the FIFO bound
          run_left = ready_state ? 4 + rand_bits(3) : rand_bits(5);
        end else begin
          run_left--;
        end
      end
      out_ready <= ready_state & (received < n_recv);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] raw;
    logic [31:0] div_model;
    logic [31:0] ctrl_val;
    logic [31:0] data;
    logic [1:0]  resp;

    lfsr_q    = LfsrSeed;
    rst_n     <= 1'b0;
    axil_req  <= '0;
    in_valid  <= 1'b0;
    in_data   <= '0;
    out_ready <= 1'b0;
    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values
    @(negedge clk);
    check_value("in_ready_o", 32'(in_ready), 0);
    check_value("out_valid_o", 32'(out_valid), 0);
    check_value("clk_ena_o", 32'(clk_ena), 0);
    check_value("isolate_o", 32'(iso), 0);
    check_value("ddr_rcv_clk_o", 32'(ddr_clk), 0);
    check_value("bvalid", 32'(axil_rsp.bvalid), 0);
    check_value("rvalid", 32'(axil_rsp.rvalid), 0);
    expect_read(`SL_REG_CTRL, 0, RespOkay, "CTRL");
    expect_read(`SL_REG_CLK_DIV, `SL_MIN_CLK_DIV, RespOkay, "CLK_DIV");
    expect_read(`SL_REG_TX_COUNT, 0, RespOkay, "TX_COUNT");
    expect_read(`SL_REG_RX_COUNT, 0, RespOkay, "RX_COUNT");

    // Divider writes
    div_model = `SL_MIN_CLK_DIV;
    for (int i = 0; i < 12; i++) begin
      raw       = rand_bits(7);
      div_model = expected_div(raw);
      expect_write(`SL_REG_CLK_DIV, raw, RespOkay, "CLK_DIV");
      expect_read(`SL_REG_CLK_DIV, div_model, RespOkay, "CLK_DIV");
    end

    // Read-only and unmapped offsets
    expect_write(`SL_REG_STATUS, 32'hFFFF_FFFF, RespSlverr, "STATUS");
    expect_write(`SL_REG_TX_COUNT, 32'h7, RespSlverr, "TX_COUNT");
    expect_write(`SL_REG_RX_COUNT, 32'h7, RespSlverr, "RX_COUNT");
    expect_write(5'h14, 32'h7, RespSlverr, "offset 0x14");
    expect_write(5'h1C, 32'h7, RespSlverr, "offset 0x1C");
    expect_read(`SL_REG_CTRL, 0, RespOkay, "CTRL");
    expect_read(`SL_REG_CLK_DIV, div_model, RespOkay, "CLK_DIV");
    expect_read(`SL_REG_TX_COUNT, 0, RespOkay, "TX_COUNT");
    expect_read(5'h14, 0, RespSlverr, "offset 0x14");
    expect_read(5'h18, 0, RespSlverr, "offset 0x18");
    expect_read(5'h1C, 0, RespSlverr, "offset 0x1C");

    // Control bits reach the ports and STATUS
    for (int v = 0; v < 8; v++) begin
      expect_write(`SL_REG_CTRL, 32'(v), RespOkay, "CTRL");
      @(negedge clk);
      check_value("clk_ena_o", 32'(clk_ena), 32'(v & 1));
      check_value("isolate_o", 32'(iso), 32'((v >> 1) & 3));
      expect_read(`SL_REG_CTRL, 32'(v), RespOkay, "CTRL");
      expect_read(`SL_REG_STATUS, 32'((v >> 1) & 3), RespOkay, "STATUS");
    end

    ////////////////////////////////////////
    // Streaming
    ////////////////////////////////////////

    expect_write(`SL_REG_CTRL, 32'h1, RespOkay, "CTRL");
    for (int b = 0; b < NumBatches; b++) begin
      div_model = `SL_MIN_CLK_DIV + 32'd2 * (rand_bits(3) % 32'd7);
      raw       = div_model | rand_bits(1);
      expect_write(`SL_REG_CLK_DIV, raw, RespOkay, "CLK_DIV");
      expect_read(`SL_REG_CLK_DIV, expected_div(raw), RespOkay, "CLK_DIV");
      run_stream(BatchLen, BatchLen, (b % 2) == 1);
    end
    expect_read(`SL_REG_TX_COUNT, sent_total, RespOkay, "TX_COUNT");
    expect_read(`SL_REG_RX_COUNT, sent_total, RespOkay, "RX_COUNT");

    ////////////////////////////////////////
    // Isolation
    ////////////////////////////////////////

    expect_write(`SL_REG_CTRL, 32'h3, RespOkay, "CTRL");
    @(posedge clk);
    in_valid <= 1'b1;
    in_data  <= rand_bits(32);
    repeat (IsoInCycles) begin
      @(negedge clk);
      check_value("in_ready_o", 32'(in_ready), 0);
    end
    @(posedge clk);
    in_valid <= 1'b0;

    ctrl_val = 32'h5;
    expect_write(`SL_REG_CTRL, ctrl_val, RespOkay, "CTRL");
    run_stream(IsoPayloads, 0, 1'b0);
    @(posedge clk);
    out_ready <= 1'b1;
    // Held payloads pile up in the receive FIFO
    do begin
      axil_read(`SL_REG_STATUS, data, resp);
      @(negedge clk);
      check_value("out_valid_o", 32'(out_valid), 0);
    end while (data[6:4] != 3'(IsoPayloads));
    check_value("STATUS rdata", data, (IsoPayloads << 4) | ((ctrl_val >> 1) & 3));
    @(posedge clk);
    out_ready <= 1'b0;

    expect_write(`SL_REG_CTRL, 32'h1, RespOkay, "CTRL");
    run_stream(0, IsoPayloads, 1'b0);
    // Receive FIFO is empty once every sent payload came out
    expect_read(`SL_REG_STATUS, 0, RespOkay, "STATUS");
    expect_read(`SL_REG_TX_COUNT, sent_total, RespOkay, "TX_COUNT");
    expect_read(`SL_REG_RX_COUNT, sent_total, RespOkay, "RX_COUNT");

    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Run limit from the test lengths at the largest divider
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not complete within %0d cycles", TimeoutCycles);
      $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
      $display("Verification failed");
      $finish;
    end
  end

endmodule

//--- serial_link.f
+incdir+source
source/serial_link_pkg.sv
source/sl_fifo.sv
source/sl_cfg_regs.sv
source/sl_tx_phy.sv
source/sl_rx_phy.sv
source/serial_link.sv
tb/tb_serial_link.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_serial_link
FILELIST  := serial_link.f
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
